// ==== axi_rd_pkg.sv ====
`default_nettype none

package axi_rd_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channel widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Top ID bit carries the core index.
	localparam int AXI_ID_WIDTH = 4;
	localparam int AXI_ADDR_WIDTH = 32;
	localparam int AXI_DATA_WIDTH = 32;

	// Cores sharing the identification block.
	localparam int N_CORES = 2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channel payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Read address. Burst is len+1 beats.
	typedef struct packed {
		logic [AXI_ID_WIDTH-1:0] id;
		logic [AXI_ADDR_WIDTH-1:0] addr;
		logic [3:0] len;
	} ar_t;

	// One read data beat.
	typedef struct packed {
		logic [AXI_ID_WIDTH-1:0] id;
		logic [AXI_DATA_WIDTH-1:0] data;
		logic last;
	} r_t;

endpackage

`default_nettype wire

// ==== chan_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module chan_slice #(
	parameter type payload_t = logic [7:0]
) (
	input wire logic clk_i,
	input wire logic rst_n,
	input wire logic in_valid,
	output logic in_ready,
	input wire payload_t in_data,
	output logic out_valid,
	input wire logic out_ready,
	output payload_t out_data
);

	logic out_valid_q;
	logic skid_valid_q;
	payload_t out_data_q;
	payload_t skid_data_q;
	logic out_free;

	// Output register can take a new item this cycle.
	assign out_free = out_ready || !out_valid_q;

	// Ready drops only once the skid entry is also held.
	assign in_ready = !skid_valid_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			out_valid_q <= 1'b0;
			skid_valid_q <= 1'b0;
		end else if (out_free) begin
			// Skid entry drains first, input is blocked meanwhile.
			out_valid_q <= skid_valid_q || in_valid;
			skid_valid_q <= 1'b0;
		end else if (in_valid && in_ready) begin
			skid_valid_q <= 1'b1;
		end
	end

	// Payload storage.
	always_ff @(posedge clk_i) begin
		if (out_free) begin
			if (skid_valid_q) begin
				out_data_q <= skid_data_q;
			end else if (in_valid) begin
				out_data_q <= in_data;
			end
		end else if (in_valid && in_ready) begin
			skid_data_q <= in_data;
		end
	end

	assign out_valid = out_valid_q;
	assign out_data = out_data_q;

	// A stalled item keeps its payload and its valid.
	assert property (@(posedge clk_i) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== rd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_arbiter (
	input wire logic clk_i,
	input wire logic rst_n,

	// Core side after the AR slices.
	input wire axi_rd_pkg::ar_t [axi_rd_pkg::N_CORES-1:0] core_ar,
	input wire logic [axi_rd_pkg::N_CORES-1:0] core_ar_valid,
	output logic [axi_rd_pkg::N_CORES-1:0] core_ar_ready,
	output axi_rd_pkg::r_t [axi_rd_pkg::N_CORES-1:0] core_r,
	output logic [axi_rd_pkg::N_CORES-1:0] core_r_valid,
	input wire logic [axi_rd_pkg::N_CORES-1:0] core_r_ready,

	// Slave side.
	output axi_rd_pkg::ar_t slv_ar,
	output logic slv_ar_valid,
	input wire logic slv_ar_ready,
	input wire axi_rd_pkg::r_t slv_r,
	input wire logic slv_r_valid,
	output logic slv_r_ready
);

	import axi_rd_pkg::*;

	localparam int TAG_BIT = AXI_ID_WIDTH - 1;

	// Two cores, so one bit names a core.
	logic rr_q;
	logic busy_q;
	logic grant_idx;
	logic r_idx;
	logic ar_fire;
	logic r_last_fire;
	r_t r_untag;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AR grant and tagging
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Round robin when both wait, else whoever is asking.
	always_comb begin
		if (core_ar_valid[0] && core_ar_valid[1]) begin
			grant_idx = rr_q;
		end else if (core_ar_valid[1]) begin
			grant_idx = 1'b1;
		end else if (core_ar_valid[0]) begin
			grant_idx = 1'b0;
		end else begin
			grant_idx = rr_q;
		end
	end

	always_comb begin
		slv_ar = core_ar[grant_idx];
		// Core index replaces whatever the core put in the top bit.
		slv_ar.id[TAG_BIT] = grant_idx;
	end

	assign slv_ar_valid = !busy_q && (|core_ar_valid);

	always_comb begin
		for (int i = 0; i < N_CORES; i++) begin
			core_ar_ready[i] = !busy_q && slv_ar_ready && (grant_idx == i[0]);
		end
	end

	assign ar_fire = slv_ar_valid && slv_ar_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// R routing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign r_idx = slv_r.id[TAG_BIT];

	always_comb begin
		r_untag = slv_r;
		r_untag.id[TAG_BIT] = 1'b0;
	end

	// Payload goes to both, valid only to the tagged core.
	always_comb begin
		for (int i = 0; i < N_CORES; i++) begin
			core_r[i] = r_untag;
			core_r_valid[i] = slv_r_valid && (r_idx == i[0]);
		end
	end

	assign slv_r_ready = core_r_ready[r_idx];

	assign r_last_fire = slv_r_valid && slv_r_ready && slv_r.last;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Burst lock
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			rr_q <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			if (ar_fire) begin
				busy_q <= 1'b1;
				// Other core gets priority next time.
				rr_q <= !grant_idx;
			end else if (r_last_fire) begin
				busy_q <= 1'b0;
			end
		end
	end

	// The lock spans the whole slave burst.
	assert property (@(posedge clk_i) disable iff (!rst_n)
		!busy_q |-> slv_ar_ready);

	// Beats come back only for an issued burst.
	assert property (@(posedge clk_i) disable iff (!rst_n)
		slv_r_valid |-> busy_q);

endmodule

`default_nettype wire

// ==== coreinfo.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreinfo #(
	parameter bit [31:0] CORE0_AXI_ID = 0,
	parameter bit [31:0] CORE0_ID = 0,
	parameter bit [31:0] CORE1_AXI_ID = 1,
	parameter bit [31:0] CORE1_ID = 0
) (
	input wire logic clk_i,
	input wire logic rst_n,
	input wire axi_rd_pkg::ar_t ar,
	input wire logic ar_valid,
	output logic ar_ready,
	output axi_rd_pkg::r_t r,
	output logic r_valid,
	input wire logic r_valid_ready
);

	import axi_rd_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_DATA
	} state_t;

	state_t read_state;
	logic [9:0] read_addr;
	logic [3:0] read_len;
	logic [3:0] read_count;
	logic [AXI_ID_WIDTH-1:0] read_id;
	logic arid;
	logic [AXI_DATA_WIDTH-1:0] core_id;
	logic last_beat;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Core ID lookup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Ready by the time the engine reaches ST_DATA.
	always_ff @(posedge clk_i) begin
		if (32'(arid) == CORE0_AXI_ID) begin
			core_id <= CORE0_ID;
		end else if (32'(arid) == CORE1_AXI_ID) begin
			core_id <= CORE1_ID;
		end else begin
			core_id <= '1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read engine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign last_beat = (read_count == read_len);

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			read_state <= ST_IDLE;
		end else begin
			case (read_state)
				ST_IDLE: begin
					if (ar_valid && ar_ready) begin
						read_state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					read_state <= ST_DATA;
				end
				ST_DATA: begin
					if (r_valid && r_valid_ready && last_beat) begin
						read_state <= ST_IDLE;
					end
				end
				default: begin
					read_state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request capture and beat count.
	always_ff @(posedge clk_i) begin
		if (read_state == ST_IDLE && ar_valid && ar_ready) begin
			read_addr <= ar.addr[11:2];
			read_len <= ar.len;
			read_count <= '0;
			read_id <= ar.id;
			arid <= ar.id[AXI_ID_WIDTH-1];
		end else if (r_valid && r_valid_ready && !last_beat) begin
			read_count <= read_count + 4'd1;
		end
	end

	assign ar_ready = (read_state == ST_IDLE);
	assign r_valid = (read_state == ST_DATA);

	// Word 0 is N_CORES and word 1 the requester's core ID. Others read all ones.
	always_comb begin
		r.id = read_id;
		r.last = r_valid && last_beat;
		if (read_addr == 10'd0) begin
			r.data = AXI_DATA_WIDTH'(N_CORES);
		end else if (read_addr == 10'd1) begin
			r.data = core_id;
		end else begin
			r.data = '1;
		end
	end

	// A stalled beat keeps its payload.
	assert property (@(posedge clk_i) disable iff (!rst_n)
		r_valid && !r_valid_ready |=> r_valid && $stable(r));

endmodule

`default_nettype wire

// ==== coreinfo_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreinfo_subsys #(
	parameter bit [31:0] CORE0_ID = 0,
	parameter bit [31:0] CORE1_ID = 0
) (
	input wire logic clk_i,
	input wire logic rst_n,
	input wire axi_rd_pkg::ar_t [axi_rd_pkg::N_CORES-1:0] core_ar,
	input wire logic [axi_rd_pkg::N_CORES-1:0] core_ar_valid,
	output logic [axi_rd_pkg::N_CORES-1:0] core_ar_ready,
	output axi_rd_pkg::r_t [axi_rd_pkg::N_CORES-1:0] core_r,
	output logic [axi_rd_pkg::N_CORES-1:0] core_r_valid,
	input wire logic [axi_rd_pkg::N_CORES-1:0] core_r_ready
);

	import axi_rd_pkg::*;

	// Slice to arbiter, per core.
	ar_t [N_CORES-1:0] slc_ar;
	logic [N_CORES-1:0] slc_ar_valid;
	logic [N_CORES-1:0] slc_ar_ready;

	// Arbiter to identification block.
	ar_t ci_ar;
	logic ci_ar_valid;
	logic ci_ar_ready;

	// Identification block into the R slice.
	r_t ci_r;
	logic ci_r_valid;
	logic ci_r_ready;

	// R slice to arbiter.
	r_t slc_r;
	logic slc_r_valid;
	logic slc_r_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Core AR slices
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar i = 0; i < N_CORES; i++) begin : g_ar_slice
		chan_slice #(
			.payload_t(ar_t)
		) u_ar_slice (
			.clk_i(clk_i),
			.rst_n(rst_n),
			.in_valid(core_ar_valid[i]),
			.in_ready(core_ar_ready[i]),
			.in_data(core_ar[i]),
			.out_valid(slc_ar_valid[i]),
			.out_ready(slc_ar_ready[i]),
			.out_data(slc_ar[i])
		);
	end

	rd_arbiter u_rd_arbiter (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.core_ar(slc_ar),
		.core_ar_valid(slc_ar_valid),
		.core_ar_ready(slc_ar_ready),
		.core_r(core_r),
		.core_r_valid(core_r_valid),
		.core_r_ready(core_r_ready),
		.slv_ar(ci_ar),
		.slv_ar_valid(ci_ar_valid),
		.slv_ar_ready(ci_ar_ready),
		.slv_r(slc_r),
		.slv_r_valid(slc_r_valid),
		.slv_r_ready(slc_r_ready)
	);

	// AXI ID of each core is its index in the top ID bit.
	coreinfo #(
		.CORE0_AXI_ID(32'd0),
		.CORE0_ID(CORE0_ID),
		.CORE1_AXI_ID(32'd1),
		.CORE1_ID(CORE1_ID)
	) u_coreinfo (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.ar(ci_ar),
		.ar_valid(ci_ar_valid),
		.ar_ready(ci_ar_ready),
		.r(ci_r),
		.r_valid(ci_r_valid),
		.r_valid_ready(ci_r_ready)
	);

	chan_slice #(
		.payload_t(r_t)
	) u_r_slice (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.in_valid(ci_r_valid),
		.in_ready(ci_r_ready),
		.in_data(ci_r),
		.out_valid(slc_r_valid),
		.out_ready(slc_r_ready),
		.out_data(slc_r)
	);

endmodule

`default_nettype wire

// ==== tb_coreinfo_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_coreinfo_subsys;

	import axi_rd_pkg::*;

	localparam bit [31:0] CORE0_ID = 32'h1000_00A0;
	localparam bit [31:0] CORE1_ID = 32'h1000_00B1;
	localparam int N_BURSTS = 40;
	// Longest burst slowed by back-pressure, plus arbitration slack.
	localparam int MAX_CYCLES = N_CORES * N_BURSTS * (16 * 4 + 20);
	localparam int SEED = 27985;

	logic clk_i;
	logic rst_n;
	ar_t [N_CORES-1:0] core_ar;
	logic [N_CORES-1:0] core_ar_valid;
	logic [N_CORES-1:0] core_ar_ready;
	r_t [N_CORES-1:0] core_r;
	logic [N_CORES-1:0] core_r_valid;
	logic [N_CORES-1:0] core_r_ready;

	// Per-core drive values.
	ar_t ar_drv [N_CORES];
	logic ar_valid_drv [N_CORES];
	logic r_ready_drv [N_CORES];

	// Issued bursts waiting for their beats.
	ar_t exp_q [N_CORES][$];
	int beat_cnt [N_CORES];
	bit stim_done [N_CORES];

	int value_errors;
	int other_errors;
	int cycle_count;

	always #50 clk_i = ~clk_i;

	assign core_ar = {ar_drv[1], ar_drv[0]};
	assign core_ar_valid = {ar_valid_drv[1], ar_valid_drv[0]};
	assign core_r_ready = {r_ready_drv[1], r_ready_drv[0]};

	coreinfo_subsys #(
		.CORE0_ID(CORE0_ID),
		.CORE1_ID(CORE1_ID)
	) u_coreinfo_subsys (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.core_ar(core_ar),
		.core_ar_valid(core_ar_valid),
		.core_ar_ready(core_ar_ready),
		.core_r(core_r),
		.core_r_valid(core_r_valid),
		.core_r_ready(core_r_ready)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Word offset inside the 4 KB block picks the register.
	function automatic logic [31:0] expected_word(input int c, input logic [31:0] addr);
		logic [31:0] word;
		case (addr[11:2])
			10'd0: word = 32'd2;
			10'd1: word = (c == 0) ? CORE0_ID : CORE1_ID;
			default: word = '1;
		endcase
		return word;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERR %0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
		end
	endtask

	// One R transfer on core c against the oldest open burst.
	task automatic check_beat(input int c);
		ar_t cur;
		logic [31:0] exp_data;
		logic [31:0] exp_id;
		logic exp_last;
		if (exp_q[c].size() == 0) begin
			other_errors++;
			$display("%0t core %0d received a read beat with no burst outstanding", $time, c);
		end else begin
			cur = exp_q[c][0];
			exp_data = expected_word(c, cur.addr);
			// Top bit comes back cleared, low bits as issued.
			exp_id = 32'({1'b0, cur.id[AXI_ID_WIDTH-2:0]});
			exp_last = (beat_cnt[c] == int'(cur.len));
			compare_value($sformatf("core%0d_r.data", c), exp_data, core_r[c].data);
			compare_value($sformatf("core%0d_r.id", c), exp_id, 32'(core_r[c].id));
			compare_value($sformatf("core%0d_r.last", c), 32'(exp_last), 32'(core_r[c].last));
			if (exp_last) begin
				void'(exp_q[c].pop_front());
				beat_cnt[c] = 0;
			end else begin
				beat_cnt[c]++;
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus and compare
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_core_stimulus(input int c);
		ar_t req;
		logic [31:0] rnd;
		int unsigned sel;
		logic accepted;
		do begin
			@(negedge clk_i);
		end while (rst_n !== 1'b1);
		for (int n = 0; n < N_BURSTS; n++) begin
			repeat ($urandom_range(0, 3)) @(negedge clk_i);
			// Top ID bit is random too since the arbiter overwrites it.
			req.id = 4'($urandom());
			req.len = 4'($urandom());
			sel = $urandom_range(0, 2);
			rnd = $urandom();
			case (sel)
				0: req.addr = 32'h0000_0000;
				1: req.addr = 32'h0000_0004;
				default: req.addr = rnd & 32'hFFFF_FFFC;
			endcase
			exp_q[c].push_back(req);
			ar_drv[c] = req;
			ar_valid_drv[c] = 1'b1;
			// Ready is registered, so its value here holds at the next edge.
			accepted = 1'b0;
			while (!accepted) begin
				accepted = core_ar_ready[c];
				@(negedge clk_i);
			end
			ar_valid_drv[c] = 1'b0;
		end
		stim_done[c] = 1'b1;
	endtask

	// Random R ready, and a check of every beat that will transfer.
	task automatic watch_core_r(input int c);
		forever begin
			@(negedge clk_i);
			if (rst_n !== 1'b1) begin
				r_ready_drv[c] = 1'b0;
			end else begin
				r_ready_drv[c] = ($urandom_range(0, 3) != 0);
				if (core_r_valid[c] && r_ready_drv[c]) begin
					check_beat(c);
				end
			end
		end
	endtask

	task automatic report_and_finish();
		$display("Summary: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	initial run_core_stimulus(0);
	initial run_core_stimulus(1);
	initial watch_core_r(0);
	initial watch_core_r(1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Run control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		clk_i = 1'b0;
		rst_n = 1'b0;
		value_errors = 0;
		other_errors = 0;
		for (int c = 0; c < N_CORES; c++) begin
			ar_drv[c] = '0;
			ar_valid_drv[c] = 1'b0;
			r_ready_drv[c] = 1'b0;
			beat_cnt[c] = 0;
			stim_done[c] = 1'b0;
		end
		void'($urandom(SEED));
		repeat (4) @(negedge clk_i);
		rst_n = 1'b1;
		while (!(stim_done[0] && stim_done[1] &&
				exp_q[0].size() == 0 && exp_q[1].size() == 0)) begin
			@(negedge clk_i);
		end
		// Idle tail where any stray beat would show up.
		repeat (20) @(negedge clk_i);
		report_and_finish();
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk_i);
			cycle_count++;
		end
		other_errors++;
		$display("timeout: bursts still outstanding");
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
axi_rd_pkg.sv
chan_slice.sv
rd_arbiter.sv
coreinfo.sv
coreinfo_subsys.sv
tb_coreinfo_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the coreinfo subsystem testbench with Verilator.
set -u

cd "$(dirname "$0")"

TOP=tb_coreinfo_subsys
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -f filelist.f -o "sim_$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
